// File: hw/cinema_pkg.sv
`default_nettype none

package cinema_pkg;

    // --------------------------------------------------
    // widths with a meaning
    typedef logic [5:0]  ticket_id_t;
    typedef logic [5:0]  movie_id_t;
    typedef logic [31:0] index_t;  // store index and ticket count
    typedef logic [9:0]  price_t;  // two 5-bit decimal digits
    typedef logic [4:0]  glyph_t;

    localparam int BLINK_W   = 32;          // blink divider width
    localparam int BLINK_DEF = 50_000_000;

    // --------------------------------------------------
    // display glyph codes, 0..9 are digits
    localparam glyph_t G_A     = 5'd10;
    localparam glyph_t G_B     = 5'd11;
    localparam glyph_t G_C     = 5'd12;
    localparam glyph_t G_D     = 5'd13;
    localparam glyph_t G_E     = 5'd14;
    localparam glyph_t G_F     = 5'd15;
    localparam glyph_t G_H     = 5'd16;
    localparam glyph_t G_I     = 5'd17;
    localparam glyph_t G_J     = 5'd18;
    localparam glyph_t G_L     = 5'd19;
    localparam glyph_t G_N     = 5'd20;
    localparam glyph_t G_O     = 5'd21;
    localparam glyph_t G_P     = 5'd22;
    localparam glyph_t G_M     = 5'd23;
    localparam glyph_t G_R     = 5'd24;
    localparam glyph_t G_T     = 5'd25;
    localparam glyph_t G_U     = 5'd26;
    localparam glyph_t G_V     = 5'd27;
    localparam glyph_t G_Y     = 5'd28;
    localparam glyph_t G_G     = 5'd30;
    localparam glyph_t G_BLANK = 5'd31;

    typedef struct packed {
        glyph_t g0;  // leftmost
        glyph_t g1;
        glyph_t g2;
        glyph_t g3;
        glyph_t g4;
        glyph_t g5;
    } show_t;

    // --------------------------------------------------
    // store records
    typedef enum logic [1:0] {
        SOLD     = 2'd0,
        USED     = 2'd1,
        REFUNDED = 2'd2
    } ticket_state_t;

    typedef struct packed {
        ticket_id_t    id;
        logic [4:0]    movie_num;
        logic [14:0]   session;   // three 5-bit digits
        logic [9:0]    buy_time;
        price_t        price;
        ticket_state_t state;
        logic [9:0]    seat;
        movie_id_t     movie_id;
        logic          vip;
    } ticket_rec_t;

    typedef struct packed {
        movie_id_t   id;
        logic [4:0]  title;
        price_t      price;
        logic [14:0] schedule;
        logic [4:0]  free_seats;
        logic [3:0]  seat_map;
        logic        valid;
    } movie_rec_t;

    // --------------------------------------------------
    // store handshake
    typedef enum logic [2:0] {
        OP_IDLE       = 3'd0,
        OP_NEW        = 3'd1,
        OP_READ_ID    = 3'd2,
        OP_CHANGE_ID  = 3'd3,
        OP_DELETE_ID  = 3'd4,
        OP_READ_INDEX = 3'd5,
        OP_CLEAR      = 3'd7
    } store_op_t;

    typedef struct packed {
        store_op_t   op;
        index_t      index;
        ticket_id_t  id;
        ticket_rec_t data;
    } ticket_req_t;

    typedef struct packed {
        logic        over;   // one-cycle answer strobe
        logic        wrong;
        index_t      count;
        ticket_rec_t data;
    } ticket_rsp_t;

    typedef struct packed {
        store_op_t  op;
        movie_id_t  id;
        movie_rec_t data;
    } movie_req_t;

    typedef struct packed {
        logic       over;
        movie_rec_t data;
    } movie_rsp_t;

    // --------------------------------------------------
    // keys and pages
    typedef enum logic [2:0] {
        KEY_NEXT    = 3'd0,
        KEY_HOME    = 3'd1,
        KEY_CONFIRM = 3'd2,
        KEY_BACK    = 3'd3,
        KEY_CANCEL  = 3'd4,
        KEY_NONE    = 3'd7
    } key_t;

    typedef enum logic [2:0] {
        PG_NONE,
        PG_BROWSE,
        PG_PROMPT,
        PG_PRICE,
        PG_ERROR
    } page_t;

endpackage

`default_nettype wire

// File: hw/ticket_browser.sv
`timescale 1ns/1ns
`default_nettype none

module ticket_browser import cinema_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire key_t        key_i,
    input  wire              active_i,
    output ticket_req_t      req_o,
    input  wire ticket_rsp_t rsp_i,
    output ticket_rec_t      cur_o
);

    index_t    index_q;
    logic      pending_q;
    logic      active_q;
    store_op_t op_q;
    logic      idle;

    assign idle = (op_q == OP_IDLE);

    // --------------------------------------------------
    // index stepping and read-by-index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q   <= index_t'(1);
            pending_q <= 1'b1;  // first record after reset
            active_q  <= 1'b1;
            op_q      <= OP_IDLE;
            cur_o     <= '0;
        end else begin
            active_q <= active_i;
            if (!idle) begin
                if (rsp_i.over) begin
                    op_q  <= OP_IDLE;   // at least one idle cycle follows
                    cur_o <= rsp_i.data;
                end
            end else if (active_i) begin
                if (!active_q) begin
                    pending_q <= 1'b1;  // back from the refund pages
                end else begin
                    case (key_i)
                        KEY_NEXT: begin
                            if (index_q < rsp_i.count) begin
                                index_q <= index_q + index_t'(1);
                            end
                            pending_q <= 1'b1;
                        end
                        KEY_BACK: begin
                            if (index_q > index_t'(1)) begin
                                index_q <= index_q - index_t'(1);
                            end
                            pending_q <= 1'b1;
                        end
                        KEY_HOME, KEY_CANCEL: begin
                            index_q   <= index_t'(1);
                            pending_q <= 1'b1;
                        end
                        default: begin
                            // empty store has nothing to read
                            if (pending_q && rsp_i.count != '0) begin
                                op_q      <= OP_READ_INDEX;
                                pending_q <= 1'b0;
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.op    = op_q;
        req_o.index = index_q;  // held, keys ignored in flight
    end

endmodule

`default_nettype wire

// File: hw/refund_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module refund_ctrl import cinema_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire key_t        key_i,
    input  wire ticket_id_t  refund_id_i,
    input  wire ticket_req_t browse_req_i,
    output ticket_rsp_t      browse_rsp_o,
    output ticket_req_t      ticket_req_o,
    input  wire ticket_rsp_t ticket_rsp_i,
    output movie_req_t       movie_req_o,
    input  wire movie_rsp_t  movie_rsp_i,
    output logic             browse_active_o,
    output page_t            page_o,
    output price_t           price_o
);

    typedef enum logic [2:0] {
        BROWSE,
        ENTER_ID,
        LOOKUP,
        READ_MOVIE,
        WRITE_BACK,
        SHOW_PRICE,
        SHOW_ERROR
    } state_t;

    state_t      state_q;
    store_op_t   t_op_q;
    store_op_t   m_op_q;
    logic        t_done_q;
    logic        m_done_q;
    ticket_id_t  t_id_q;
    ticket_rec_t t_data_q;  // already marked refunded
    movie_id_t   m_id_q;
    movie_rec_t  m_data_q;  // seat count already bumped
    logic        leave_key;

    assign leave_key = (key_i == KEY_CONFIRM) || (key_i == KEY_HOME) ||
                       (key_i == KEY_CANCEL);

    // --------------------------------------------------
    // mode and refund sequence
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= BROWSE;
            t_op_q   <= OP_IDLE;
            m_op_q   <= OP_IDLE;
            t_done_q <= 1'b0;
            m_done_q <= 1'b0;
        end else begin
            case (state_q)
                BROWSE: begin
                    if (key_i == KEY_CONFIRM && browse_req_i.op == OP_IDLE) begin
                        state_q <= ENTER_ID;
                    end
                end
                ENTER_ID: begin
                    if (key_i == KEY_CONFIRM) begin
                        t_op_q  <= OP_READ_ID;
                        state_q <= LOOKUP;
                    end else if (key_i == KEY_CANCEL || key_i == KEY_HOME) begin
                        state_q <= BROWSE;
                    end
                end
                LOOKUP: begin
                    if (ticket_rsp_i.over) begin
                        t_op_q <= OP_IDLE;
                        if (ticket_rsp_i.wrong || ticket_rsp_i.data.state != SOLD) begin
                            state_q <= SHOW_ERROR;
                        end else begin
                            m_op_q  <= OP_READ_ID;
                            state_q <= READ_MOVIE;
                        end
                    end
                end
                READ_MOVIE: begin
                    if (movie_rsp_i.over) begin
                        m_op_q   <= OP_IDLE;
                        t_done_q <= 1'b0;
                        m_done_q <= 1'b0;
                        state_q  <= WRITE_BACK;
                    end
                end
                WRITE_BACK: begin
                    // each store is issued after its idle gap, answers in any order
                    if (!t_done_q) begin
                        if (t_op_q == OP_IDLE) begin
                            t_op_q <= OP_CHANGE_ID;
                        end else if (ticket_rsp_i.over) begin
                            t_op_q   <= OP_IDLE;
                            t_done_q <= 1'b1;
                        end
                    end
                    if (!m_done_q) begin
                        if (m_op_q == OP_IDLE) begin
                            m_op_q <= OP_CHANGE_ID;
                        end else if (movie_rsp_i.over) begin
                            m_op_q   <= OP_IDLE;
                            m_done_q <= 1'b1;
                        end
                    end
                    if (t_done_q && m_done_q) begin
                        state_q <= SHOW_PRICE;
                    end
                end
                SHOW_PRICE, SHOW_ERROR: begin
                    if (leave_key) begin
                        state_q <= BROWSE;
                    end
                end
                default: state_q <= BROWSE;
            endcase
        end
    end

    // --------------------------------------------------
    // record rewrite
    always_ff @(posedge clk) begin
        if (state_q == ENTER_ID && key_i == KEY_CONFIRM) begin
            t_id_q <= refund_id_i;
        end
        if (state_q == LOOKUP && ticket_rsp_i.over) begin
            t_data_q       <= ticket_rsp_i.data;
            t_data_q.state <= REFUNDED;
            m_id_q         <= ticket_rsp_i.data.movie_id;
        end
        if (state_q == READ_MOVIE && movie_rsp_i.over) begin
            m_data_q            <= movie_rsp_i.data;
            m_data_q.free_seats <= movie_rsp_i.data.free_seats + 5'd1;
            m_data_q.valid      <= 1'b1;
        end
    end

    // ticket port belongs to the browser only in browse mode
    always_comb begin
        if (state_q == BROWSE) begin
            ticket_req_o = browse_req_i;
        end else begin
            ticket_req_o      = '0;
            ticket_req_o.op   = t_op_q;
            ticket_req_o.id   = t_id_q;
            ticket_req_o.data = t_data_q;
        end
        browse_rsp_o      = ticket_rsp_i;
        browse_rsp_o.over = ticket_rsp_i.over && (state_q == BROWSE);
    end

    always_comb begin
        movie_req_o      = '0;
        movie_req_o.op   = m_op_q;
        movie_req_o.id   = m_id_q;
        movie_req_o.data = m_data_q;
    end

    always_comb begin
        case (state_q)
            BROWSE:                                    page_o = PG_BROWSE;
            ENTER_ID, LOOKUP, READ_MOVIE, WRITE_BACK:  page_o = PG_PROMPT;
            SHOW_PRICE:                                page_o = PG_PRICE;
            SHOW_ERROR:                                page_o = PG_ERROR;
            default:                                   page_o = PG_NONE;
        endcase
    end

    assign browse_active_o = (state_q == BROWSE);
    assign price_o         = t_data_q.price;

endmodule

`default_nettype wire

// File: hw/display_fmt.sv
`timescale 1ns/1ns
`default_nettype none

module display_fmt import cinema_pkg::*; #(
    parameter int BLINK_CYCLES = BLINK_DEF
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire page_t       page_i,
    input  wire index_t      count_i,
    input  wire ticket_rec_t cur_i,
    input  wire price_t      price_i,
    output show_t            show_o
);

    logic [BLINK_W-1:0] blink_cnt_q;
    logic               second_q;  // showing browse page 2
    show_t              page1;
    show_t              page2;
    show_t              show_d;

    // --------------------------------------------------
    // blink divider, restarts on page 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blink_cnt_q <= '0;
            second_q    <= 1'b0;
        end else if (page_i != PG_BROWSE) begin
            blink_cnt_q <= '0;
            second_q    <= 1'b0;
        end else if (blink_cnt_q == BLINK_W'(BLINK_CYCLES - 1)) begin
            blink_cnt_q <= '0;
            second_q    <= ~second_q;
        end else begin
            blink_cnt_q <= blink_cnt_q + 1'b1;
        end
    end

    // --------------------------------------------------
    // page builders
    assign page1 = {glyph_t'(cur_i.id[5:3]),   // octal id
                    glyph_t'(cur_i.id[2:0]),
                    cur_i.movie_num,
                    cur_i.session[14:10],
                    cur_i.session[9:5],
                    cur_i.session[4:0]};

    assign page2 = {cur_i.buy_time[9:5],
                    cur_i.buy_time[4:0],
                    cur_i.price[9:5],
                    cur_i.price[4:0],
                    glyph_t'(cur_i.state),
                    cur_i.vip ? G_V : G_BLANK};

    always_comb begin
        case (page_i)
            PG_BROWSE: begin
                if (count_i == '0) begin
                    show_d = {G_BLANK, G_N, G_O, G_N, G_E, G_BLANK};
                end else begin
                    show_d = second_q ? page2 : page1;
                end
            end
            PG_PROMPT: show_d = {G_I, G_D, G_BLANK, G_BLANK, G_BLANK, G_BLANK};
            PG_PRICE: begin
                show_d = {G_BLANK, G_BLANK, price_i[9:5], price_i[4:0], G_BLANK, G_BLANK};
            end
            PG_ERROR:  show_d = {G_BLANK, G_E, G_R, G_R, G_O, G_R};
            default:   show_d = {6{G_BLANK}};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            show_o <= {6{G_BLANK}};
        end else begin
            show_o <= show_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/refund_desk_top.sv
`timescale 1ns/1ns
`default_nettype none

module refund_desk_top import cinema_pkg::*; #(
    parameter int BLINK_CYCLES = BLINK_DEF
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire key_t        key_i,
    input  wire ticket_id_t  refund_id_i,
    output ticket_req_t      ticket_req_o,
    input  wire ticket_rsp_t ticket_rsp_i,
    output movie_req_t       movie_req_o,
    input  wire movie_rsp_t  movie_rsp_i,
    output show_t            show_o
);

    ticket_req_t browse_req;
    ticket_rsp_t browse_rsp;  // over masked outside browse
    ticket_rec_t cur_rec;
    logic        browse_active;
    page_t       page;
    price_t      refund_price;

    // --------------------------------------------------
    ticket_browser u_browser (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_i    (key_i),
        .active_i (browse_active),
        .req_o    (browse_req),
        .rsp_i    (browse_rsp),
        .cur_o    (cur_rec)
    );

    refund_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .key_i           (key_i),
        .refund_id_i     (refund_id_i),
        .browse_req_i    (browse_req),
        .browse_rsp_o    (browse_rsp),
        .ticket_req_o    (ticket_req_o),
        .ticket_rsp_i    (ticket_rsp_i),
        .movie_req_o     (movie_req_o),
        .movie_rsp_i     (movie_rsp_i),
        .browse_active_o (browse_active),
        .page_o          (page),
        .price_o         (refund_price)
    );

    display_fmt #(
        .BLINK_CYCLES (BLINK_CYCLES)
    ) u_display (
        .clk     (clk),
        .rst_n   (rst_n),
        .page_i  (page),
        .count_i (ticket_rsp_i.count),
        .cur_i   (cur_rec),
        .price_i (refund_price),
        .show_o  (show_o)
    );

endmodule

`default_nettype wire

// File: test/tb_refund_desk.sv
`timescale 1ns/1ns
`default_nettype none

module tb_refund_desk import cinema_pkg::*;;

    localparam int WAIT_LIMIT = 100;  // cycles per wait loop

    logic        clk;
    logic        rst_n;
    key_t        key_i;
    ticket_id_t  refund_id_i;
    ticket_req_t ticket_req;
    ticket_rsp_t ticket_rsp;
    movie_req_t  movie_req;
    movie_rsp_t  movie_rsp;
    show_t       show_o;

    logic        t_over;
    logic        t_wrong;
    ticket_rec_t t_data;
    index_t      t_count;
    logic        m_over;
    movie_rec_t  m_data;

    ticket_rec_t tickets [1:8];
    movie_rec_t  movies [0:63];
    ticket_rec_t exp_tickets[$];
    ticket_rec_t got_tickets[$];
    movie_rec_t  exp_movies[$];
    movie_rec_t  got_movies[$];
    int          errors = 0;
    int          timeouts = 0;
    int          ticket_reads = 0;    // OP_READ_ID seen by the ticket store
    int          ticket_changes = 0;
    int          movie_changes = 0;

    assign ticket_rsp = {t_over, t_wrong, t_count, t_data};
    assign movie_rsp  = {m_over, m_data};

    refund_desk_top #(
        .BLINK_CYCLES (8)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_i        (key_i),
        .refund_id_i  (refund_id_i),
        .ticket_req_o (ticket_req),
        .ticket_rsp_i (ticket_rsp),
        .movie_req_o  (movie_req),
        .movie_rsp_i  (movie_rsp),
        .show_o       (show_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // reference model
    function automatic show_t expect_show(input page_t pg, input ticket_rec_t rec,
                                          input price_t price, input logic second,
                                          input index_t count);
        show_t s;
        s = {6{G_BLANK}};
        case (pg)
            PG_BROWSE: begin
                if (count == 0) begin
                    s.g1 = G_N;
                    s.g2 = G_O;
                    s.g3 = G_N;
                    s.g4 = G_E;
                end else if (!second) begin
                    s.g0 = glyph_t'(rec.id[5:3]);  // octal id
                    s.g1 = glyph_t'(rec.id[2:0]);
                    s.g2 = rec.movie_num;
                    s.g3 = rec.session[14:10];
                    s.g4 = rec.session[9:5];
                    s.g5 = rec.session[4:0];
                end else begin
                    s.g0 = rec.buy_time[9:5];
                    s.g1 = rec.buy_time[4:0];
                    s.g2 = rec.price[9:5];
                    s.g3 = rec.price[4:0];
                    s.g4 = glyph_t'(rec.state);
                    s.g5 = rec.vip ? G_V : G_BLANK;
                end
            end
            PG_PROMPT: begin
                s.g0 = G_I;
                s.g1 = G_D;
            end
            PG_PRICE: begin
                s.g2 = price[9:5];
                s.g3 = price[4:0];
            end
            PG_ERROR: begin
                s.g1 = G_E;
                s.g2 = G_R;
                s.g3 = G_R;
                s.g4 = G_O;
                s.g5 = G_R;
            end
            default: ;
        endcase
        return s;
    endfunction

    function automatic ticket_rec_t refunded_ticket(input ticket_rec_t t);
        t.state = REFUNDED;
        return t;
    endfunction

    function automatic movie_rec_t refunded_movie(input movie_rec_t m);
        m.free_seats = m.free_seats + 5'd1;
        m.valid      = 1'b1;
        return m;
    endfunction

    function automatic logic [4:0] digit();
        return 5'($urandom_range(9, 0));
    endfunction

    function automatic int find_ticket(input ticket_id_t id);
        int slot;
        slot = 0;
        for (int i = 1; i <= 8; i++) begin
            if (i <= t_count && tickets[i].id == id) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    // --------------------------------------------------
    // compare tasks
    task automatic check_show(input string name, input show_t exp, input show_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ticket(input string name, input ticket_rec_t exp,
                                input ticket_rec_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_movie(input string name, input movie_rec_t exp,
                               input movie_rec_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input index_t exp, input index_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input store_op_t exp, input store_op_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected op %0d, actual op %0d", name, exp, act);
        end
    endtask

    // --------------------------------------------------
    // stimulus and waits
    task automatic press(input key_t k);
        @(posedge clk);
        #2;
        key_i = k;
        @(posedge clk);
        #2;
        key_i = KEY_NONE;
    endtask

    task automatic wait_show(input string name, input show_t exp);
        int n;
        n = 0;
        while (show_o !== exp && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_show(name, exp, show_o);
    endtask

    task automatic wait_ticket_op(input store_op_t op, output ticket_req_t req);
        int n;
        n = 0;
        req = ticket_req;
        while (req.op != op && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            req = ticket_req;
            n++;
        end
        if (req.op != op) begin
            timeouts++;
            $display("timeout: the ticket store never got request op %0d", op);
        end
    endtask

    task automatic wait_ticket_over();
        int n;
        n = 0;
        while (t_over !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (t_over !== 1'b1) begin
            timeouts++;
            $display("timeout: the ticket store never answered");
        end
    endtask

    // one browse load, request index and page 1 of the loaded record
    task automatic load_and_check(input index_t idx, input string name);
        ticket_req_t req;
        wait_ticket_op(OP_READ_INDEX, req);
        check_index({name, " index"}, idx, req.index);
        wait_ticket_over();
        wait_show({name, " page 1"}, expect_show(PG_BROWSE, tickets[idx], '0, 1'b0, t_count));
    endtask

    task automatic start_refund(input ticket_id_t id);
        press(KEY_CONFIRM);
        wait_show("id prompt", expect_show(PG_PROMPT, '0, '0, 1'b0, t_count));
        @(posedge clk);
        #2;
        refund_id_i = id;
        press(KEY_CONFIRM);
    endtask

    // answer latency of 1..5 cycles, returns at the drive point
    task automatic store_latency();
        int unsigned n;
        n = $urandom_range(5, 1);
        #1;
        repeat (n - 1) begin
            @(posedge clk);
            #2;
        end
    endtask

    // --------------------------------------------------
    // store models
    initial begin : ticket_store
        ticket_req_t req;
        int          slot;
        t_over  = 1'b0;
        t_wrong = 1'b0;
        t_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (ticket_req.op != OP_IDLE) begin
                req = ticket_req;
                store_latency();
                slot    = find_ticket(req.id);
                t_wrong = 1'b0;
                t_data  = '0;
                case (req.op)
                    OP_READ_INDEX: begin
                        if (req.index >= 1 && req.index <= t_count) begin
                            t_data = tickets[req.index];
                        end else begin
                            t_wrong = 1'b1;
                        end
                    end
                    OP_READ_ID: begin
                        ticket_reads++;
                        if (slot > 0) begin
                            t_data = tickets[slot];
                        end else begin
                            t_wrong = 1'b1;  // unknown id
                        end
                    end
                    OP_CHANGE_ID: begin
                        ticket_changes++;
                        got_tickets.push_back(req.data);
                        if (slot > 0) begin
                            tickets[slot] = req.data;
                        end
                    end
                    default: t_wrong = 1'b1;
                endcase
                t_over = 1'b1;
                @(posedge clk);
                #2;
                t_over = 1'b0;
            end
        end
    end

    initial begin : movie_store
        movie_req_t req;
        m_over = 1'b0;
        m_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (movie_req.op != OP_IDLE) begin
                req = movie_req;
                store_latency();
                m_data = movies[req.id];
                if (req.op == OP_CHANGE_ID) begin
                    movie_changes++;
                    got_movies.push_back(req.data);
                    movies[req.id] = req.data;
                end
                m_over = 1'b1;
                @(posedge clk);
                #2;
                m_over = 1'b0;
            end
        end
    end

    initial begin : compare_writes
        forever begin
            @(negedge clk);
            while (exp_tickets.size() > 0 && got_tickets.size() > 0) begin
                check_ticket("refund ticket write", exp_tickets.pop_front(),
                             got_tickets.pop_front());
            end
            while (exp_movies.size() > 0 && got_movies.size() > 0) begin
                check_movie("refund movie write", exp_movies.pop_front(),
                            got_movies.pop_front());
            end
        end
    end

    // --------------------------------------------------
    initial begin : stimulus
        index_t      idx;
        key_t        k;
        int          reads_before;
        int          changes_before;
        ticket_rec_t t;
        movie_rec_t  m;
        void'($urandom(99));
        rst_n       = 1'b0;
        key_i       = KEY_NONE;
        refund_id_i = '0;
        t_count     = '0;  // store starts empty
        for (int i = 0; i < 64; i++) begin
            movies[i] = '0;
        end
        for (int i = 1; i <= 3; i++) begin
            m            = '0;
            m.id         = movie_id_t'(i);
            m.title      = digit();
            m.price      = {digit(), digit()};
            m.schedule   = {digit(), digit(), digit()};
            m.free_seats = 5'($urandom_range(20, 0));
            m.seat_map   = 4'($urandom);
            movies[i]    = m;
        end
        for (int i = 1; i <= 8; i++) begin
            t           = '0;
            t.id        = ticket_id_t'(i * 9 + 3);  // ids 12..75 wrap, 63 stays unused
            t.movie_num = digit();
            t.session   = {digit(), digit(), digit()};
            t.buy_time  = {digit(), digit()};
            t.price     = {digit(), digit()};
            t.state     = (i == 5) ? USED : SOLD;
            t.seat      = 10'($urandom);
            t.movie_id  = movie_id_t'(i % 3 + 1);
            t.vip       = 1'($urandom);
            tickets[i]  = t;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // empty store
        repeat (5) begin
            @(posedge clk);
            #1;
            check_op("empty store ticket op", OP_IDLE, ticket_req.op);
            check_op("empty store movie op", OP_IDLE, movie_req.op);
        end
        wait_show("empty store page", expect_show(PG_BROWSE, '0, '0, 1'b0, '0));

        // browse five tickets
        @(posedge clk);
        #2;
        t_count = 5;
        load_and_check(1, "first record");
        wait_show("first record page 2", expect_show(PG_BROWSE, tickets[1], '0, 1'b1, 5));
        idx = 1;
        for (int i = 0; i < 8; i++) begin
            k = (i < 6) ? KEY_NEXT : KEY_BACK;
            if (k == KEY_NEXT && idx < 5) begin
                idx = idx + 1;
            end else if (k == KEY_BACK && idx > 1) begin
                idx = idx - 1;
            end
            press(k);
            load_and_check(idx, "browse step");
        end

        // refund of a sold ticket
        exp_tickets.push_back(refunded_ticket(tickets[2]));
        exp_movies.push_back(refunded_movie(movies[tickets[2].movie_id]));
        start_refund(tickets[2].id);
        wait_show("refund price page", expect_show(PG_PRICE, '0, tickets[2].price, 1'b0, 5));
        press(KEY_CONFIRM);
        load_and_check(idx, "after refund");

        // unknown id, then the same ticket again
        changes_before = ticket_changes + movie_changes;
        start_refund(6'd63);
        wait_show("unknown id page", expect_show(PG_ERROR, '0, '0, 1'b0, 5));
        press(KEY_HOME);
        load_and_check(idx, "after unknown id");
        start_refund(tickets[2].id);
        wait_show("second refund page", expect_show(PG_ERROR, '0, '0, 1'b0, 5));
        press(KEY_CANCEL);
        load_and_check(idx, "after second refund");
        if (ticket_changes + movie_changes != changes_before) begin
            errors++;
            $display("a rejected refund wrote to a store");
        end

        // cancel during id entry
        press(KEY_HOME);
        load_and_check(1, "home key");
        reads_before   = ticket_reads;
        changes_before = ticket_changes + movie_changes;
        press(KEY_CONFIRM);
        wait_show("cancel prompt", expect_show(PG_PROMPT, '0, '0, 1'b0, 5));
        press(KEY_CANCEL);
        load_and_check(1, "after cancel");
        if (ticket_reads != reads_before || ticket_changes + movie_changes != changes_before) begin
            errors++;
            $display("a cancelled refund still sent a request to a store");
        end

        repeat (2) @(posedge clk);
        if (exp_tickets.size() != 0 || exp_movies.size() != 0) begin
            errors++;
            $display("a store never received its refund write");
        end
        if (got_tickets.size() != 0 || got_movies.size() != 0) begin
            errors++;
            $display("a store received a change request that was not expected");
        end
        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/cinema_pkg.sv
hw/ticket_browser.sv
hw/refund_ctrl.sv
hw/display_fmt.sv
hw/refund_desk_top.sv
test/tb_refund_desk.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_refund_desk
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LOG       ?= sim.log
FILELIST  ?= vlog.f
FAIL_MSG  ?= Simulation failed

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
